// ==== common/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_ORN,
        OP_ANDN,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_PCADDU,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU,
        OP_B,
        OP_BL,
        OP_JIRL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W,
        OP_RDCNTVL,
        OP_RDCNTVH
    } ex_op_e;

    // Result family written back to the register file
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_MOVE,
        SEL_ARITH,
        SEL_JUMP,
        SEL_CNT
    } res_sel_e;

    typedef enum logic [3:0] {
        EXCP_NONE     = 4'h0,
        EXCP_UPSTREAM = 4'h8,
        EXCP_ALE      = 4'h9
    } excp_code_e;

    typedef enum logic [2:0] {
        MD_MUL,
        MD_MULH,
        MD_MULHU,
        MD_DIV,
        MD_DIVU,
        MD_MOD,
        MD_MODU
    } muldiv_mode_e;

    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        ex_op_e           op;
        res_sel_e         sel;
        logic [1:0][4:0]  rs_addr;
        logic [1:0][31:0] rs_data;
        logic [31:0]      imm;
        logic             use_imm;
        logic             wen;
        logic [4:0]       waddr;
        logic             excp;
        excp_code_e       excp_code;
    } dispatch_t;

    // One memory-stage write slot
    typedef struct packed {
        logic        wen;
        logic        is_load;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } mem_fwd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ex_op_e      op;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        excp;
        excp_code_e  excp_code;
        logic        last_in_block;
    } ex_mem_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branch_t;

endpackage

`default_nettype wire

// ==== ex/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_op_e op_i,
    input  logic [31:0]    a_i,
    input  logic [31:0]    b_i,
    input  logic [31:0]    pc_i,
    output logic [31:0]    logic_o,
    output logic [31:0]    shift_o,
    output logic [31:0]    move_o,
    output logic [31:0]    arith_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ex_pkg::OP_AND:  logic_o = a_i & b_i;
            ex_pkg::OP_OR:   logic_o = a_i | b_i;
            ex_pkg::OP_XOR:  logic_o = a_i ^ b_i;
            ex_pkg::OP_NOR:  logic_o = ~(a_i | b_i);
            ex_pkg::OP_ORN:  logic_o = a_i | ~b_i;
            ex_pkg::OP_ANDN: logic_o = a_i & ~b_i;
            default:         logic_o = 32'd0;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_SLL: shift_o = a_i << shamt;
            ex_pkg::OP_SRL: shift_o = a_i >> shamt;
            // Sign fill from bit 31
            ex_pkg::OP_SRA: shift_o = $signed(a_i) >>> shamt;
            default:        shift_o = 32'd0;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_LUI:    move_o = b_i;
            ex_pkg::OP_PCADDU: move_o = pc_i + b_i;
            default:           move_o = 32'd0;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD:  arith_o = a_i + b_i;
            ex_pkg::OP_SUB:  arith_o = a_i - b_i;
            ex_pkg::OP_SLT:  arith_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ex_pkg::OP_SLTU: arith_o = {31'd0, a_i < b_i};
            default:         arith_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== ex/ex_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  logic            instr_valid_i,
    input  ex_pkg::ex_op_e  op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    input  logic [31:0]     pc_i,
    input  logic [31:0]     imm_i,
    output ex_pkg::branch_t branch_o
);

    logic cond;

    always_comb begin
        case (op_i)
            ex_pkg::OP_B,
            ex_pkg::OP_BL,
            ex_pkg::OP_JIRL: cond = 1'b1;
            ex_pkg::OP_BEQ:  cond = a_i == b_i;
            ex_pkg::OP_BNE:  cond = a_i != b_i;
            ex_pkg::OP_BLT:  cond = $signed(a_i) < $signed(b_i);
            ex_pkg::OP_BGE:  cond = $signed(a_i) >= $signed(b_i);
            ex_pkg::OP_BLTU: cond = a_i < b_i;
            ex_pkg::OP_BGEU: cond = a_i >= b_i;
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        branch_o.taken = instr_valid_i & cond;
        // Register-relative only for JIRL
        if (op_i == ex_pkg::OP_JIRL) begin
            branch_o.target = a_i + imm_i;
        end else begin
            branch_o.target = pc_i + imm_i;
        end
    end

endmodule

`default_nettype wire

// ==== muldiv/muldiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 abort_i,
    input  logic                 start_i,
    input  ex_pkg::muldiv_mode_e mode_i,
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    input  logic                 ack_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [31:0]          result_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e               state_q;
    logic [5:0]           cnt_q;
    ex_pkg::muldiv_mode_e mode_q;
    logic [63:0]          acc_q;
    logic [31:0]          opnd_q;
    logic [31:0]          dvd_q;
    logic                 neg_q;
    logic [31:0]          result_q;

    logic        is_signed;
    logic        is_div;
    logic        last;
    logic [31:0] a_abs;
    logic [31:0] b_abs;
    logic        neg_start;
    logic [32:0] mul_sum;
    logic [63:0] mul_nxt;
    logic [32:0] div_tmp;
    logic [32:0] div_diff;
    logic [63:0] div_nxt;
    logic [63:0] fin;
    logic [63:0] prod;
    logic [31:0] quo;
    logic [31:0] rem;
    logic [31:0] res_fin;

    // Operand conditioning at start
    always_comb begin
        is_signed = mode_i inside {ex_pkg::MD_MUL, ex_pkg::MD_MULH, ex_pkg::MD_DIV,
                                   ex_pkg::MD_MOD};
        a_abs = (is_signed && a_i[31]) ? -a_i : a_i;
        b_abs = (is_signed && b_i[31]) ? -b_i : b_i;
        if (mode_i == ex_pkg::MD_MOD) begin
            neg_start = is_signed & a_i[31];
        end else begin
            neg_start = is_signed & (a_i[31] ^ b_i[31]);
        end
    end

    assign is_div = mode_q inside {ex_pkg::MD_DIV, ex_pkg::MD_DIVU, ex_pkg::MD_MOD,
                                   ex_pkg::MD_MODU};
    // Multiply finishes on its last add, divide needs one more cycle for the fixup
    assign last   = is_div ? (cnt_q == 6'd32) : (cnt_q == 6'd31);

    // One shift-add step, multiplier in the low half
    assign mul_sum = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, opnd_q} : 33'd0);
    assign mul_nxt = {mul_sum, acc_q[31:1]};

    // One restoring step, remainder high and quotient low
    assign div_tmp  = {acc_q[63:32], acc_q[31]};
    assign div_diff = div_tmp - {1'b0, opnd_q};
    assign div_nxt  = div_diff[32] ? {div_tmp[31:0], acc_q[30:0], 1'b0}
                                   : {div_diff[31:0], acc_q[30:0], 1'b1};

    always_comb begin
        fin  = is_div ? acc_q : mul_nxt;
        prod = neg_q ? -fin : fin;
        quo  = neg_q ? -fin[31:0] : fin[31:0];
        rem  = neg_q ? -fin[63:32] : fin[63:32];
        // Min / -1 comes out as min with remainder 0 on the magnitude path
        case (mode_q)
            ex_pkg::MD_MUL:   res_fin = prod[31:0];
            ex_pkg::MD_MULH,
            ex_pkg::MD_MULHU: res_fin = prod[63:32];
            ex_pkg::MD_DIV,
            ex_pkg::MD_DIVU:  res_fin = (opnd_q == 32'd0) ? 32'hffff_ffff : quo;
            default:          res_fin = (opnd_q == 32'd0) ? dvd_q : rem;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= 6'd0;
        end else if (abort_i) begin
            state_q <= S_IDLE;
            cnt_q   <= 6'd0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_RUN;
                        cnt_q   <= 6'd0;
                    end
                end
                S_RUN: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (last) begin
                        state_q <= S_DONE;
                    end
                end
                default: begin
                    if (ack_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            mode_q <= mode_i;
            acc_q  <= {32'd0, a_abs};
            opnd_q <= b_abs;
            dvd_q  <= a_i;
            neg_q  <= neg_start;
        end else if (state_q == S_RUN) begin
            if (cnt_q < 6'd32) begin
                acc_q <= is_div ? div_nxt : mul_nxt;
            end
            if (last) begin
                result_q <= res_fin;
            end
        end
    end

    assign busy_o   = state_q != S_IDLE;
    assign done_o   = state_q == S_DONE;
    assign result_o = result_q;

endmodule

`default_nettype wire

// ==== ex/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  ex_pkg::dispatch_t      dispatch_i,
    input  ex_pkg::mem_fwd_t [1:0] mem_fwd_i,
    input  logic [63:0]            timer_64_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output ex_pkg::ex_mem_t        ex_mem_o,
    output ex_pkg::branch_t        branch_o,
    output logic                   stall_req_o
);

    logic [1:0][31:0]     rs_fwd;
    logic [31:0]          opa;
    logic [31:0]          opb;
    logic [31:0]          logic_res;
    logic [31:0]          shift_res;
    logic [31:0]          move_res;
    logic [31:0]          arith_res;
    logic                 md_op;
    ex_pkg::muldiv_mode_e md_mode;
    logic                 md_start;
    logic                 md_ack;
    logic                 md_busy;
    logic                 md_done;
    logic [31:0]          md_result;
    logic [31:0]          mem_addr;
    logic                 ale;
    ex_pkg::ex_mem_t      ex_mem_d;

    // Load forwarding, newer slot checked last so it wins
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rs_fwd[i] = dispatch_i.rs_data[i];
            for (int s = 0; s < 2; s++) begin
                if (mem_fwd_i[s].wen && mem_fwd_i[s].is_load &&
                    dispatch_i.rs_addr[i] != 5'd0 &&
                    mem_fwd_i[s].waddr == dispatch_i.rs_addr[i]) begin
                    rs_fwd[i] = mem_fwd_i[s].wdata;
                end
            end
        end
    end

    assign opa = rs_fwd[0];
    assign opb = dispatch_i.use_imm ? dispatch_i.imm : rs_fwd[1];

    ex_alu i_ex_alu (
        .op_i    (dispatch_i.op),
        .a_i     (opa),
        .b_i     (opb),
        .pc_i    (dispatch_i.pc),
        .logic_o (logic_res),
        .shift_o (shift_res),
        .move_o  (move_res),
        .arith_o (arith_res)
    );

    ex_branch i_ex_branch (
        .instr_valid_i (dispatch_i.valid),
        .op_i          (dispatch_i.op),
        .a_i           (opa),
        .b_i           (opb),
        .pc_i          (dispatch_i.pc),
        .imm_i         (dispatch_i.imm),
        .branch_o      (branch_o)
    );

    always_comb begin
        md_op = 1'b1;
        case (dispatch_i.op)
            ex_pkg::OP_MUL:   md_mode = ex_pkg::MD_MUL;
            ex_pkg::OP_MULH:  md_mode = ex_pkg::MD_MULH;
            ex_pkg::OP_MULHU: md_mode = ex_pkg::MD_MULHU;
            ex_pkg::OP_DIV:   md_mode = ex_pkg::MD_DIV;
            ex_pkg::OP_DIVU:  md_mode = ex_pkg::MD_DIVU;
            ex_pkg::OP_MOD:   md_mode = ex_pkg::MD_MOD;
            ex_pkg::OP_MODU:  md_mode = ex_pkg::MD_MODU;
            default: begin
                md_op   = 1'b0;
                md_mode = ex_pkg::MD_MUL;
            end
        endcase
    end

    assign md_start    = dispatch_i.valid & md_op & ~md_busy;
    assign stall_req_o = dispatch_i.valid & md_op & ~md_done;
    // Result leaves the unit when the EX/MEM register takes it
    assign md_ack      = dispatch_i.valid & md_op & md_done & ~stall_i;

    muldiv_unit i_muldiv_unit (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .abort_i  (flush_i),
        .start_i  (md_start),
        .mode_i   (md_mode),
        .a_i      (opa),
        .b_i      (opb),
        .ack_i    (md_ack),
        .busy_o   (md_busy),
        .done_o   (md_done),
        .result_o (md_result)
    );

    assign mem_addr = opa + dispatch_i.imm;

    always_comb begin
        case (dispatch_i.op)
            ex_pkg::OP_LD_H, ex_pkg::OP_ST_H: ale = mem_addr[0];
            ex_pkg::OP_LD_W, ex_pkg::OP_ST_W: ale = |mem_addr[1:0];
            default:                          ale = 1'b0;
        endcase
    end

    always_comb begin
        ex_mem_d.valid         = dispatch_i.valid;
        ex_mem_d.pc            = dispatch_i.pc;
        ex_mem_d.op            = dispatch_i.op;
        ex_mem_d.wen           = dispatch_i.wen & ~ale;
        ex_mem_d.waddr         = dispatch_i.waddr;
        ex_mem_d.mem_addr      = mem_addr;
        ex_mem_d.store_data    = rs_fwd[1];
        ex_mem_d.excp          = dispatch_i.excp | ale;
        ex_mem_d.last_in_block = branch_o.taken;
        // Earlier stage exception keeps its code
        if (dispatch_i.excp) begin
            ex_mem_d.excp_code = dispatch_i.excp_code;
        end else if (ale) begin
            ex_mem_d.excp_code = ex_pkg::EXCP_ALE;
        end else begin
            ex_mem_d.excp_code = ex_pkg::EXCP_NONE;
        end
        case (dispatch_i.sel)
            ex_pkg::SEL_LOGIC: ex_mem_d.wdata = logic_res;
            ex_pkg::SEL_SHIFT: ex_mem_d.wdata = shift_res;
            ex_pkg::SEL_MOVE:  ex_mem_d.wdata = move_res;
            ex_pkg::SEL_ARITH: ex_mem_d.wdata = md_op ? md_result : arith_res;
            ex_pkg::SEL_JUMP:  ex_mem_d.wdata = dispatch_i.pc + 32'd4;
            ex_pkg::SEL_CNT: begin
                if (dispatch_i.op == ex_pkg::OP_RDCNTVH) begin
                    ex_mem_d.wdata = timer_64_i[63:32];
                end else begin
                    ex_mem_d.wdata = timer_64_i[31:0];
                end
            end
            default:           ex_mem_d.wdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_o <= '0;
        end else if (flush_i) begin
            ex_mem_o <= '0;
        end else if (!stall_i) begin
            if (stall_req_o || !dispatch_i.valid) begin
                ex_mem_o <= '0;
            end else begin
                ex_mem_o <= ex_mem_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  ex_pkg::dispatch_t      dispatch_i,
    input  ex_pkg::mem_fwd_t [1:0] mem_fwd_i,
    input  logic [63:0]            timer_64_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output ex_pkg::ex_mem_t        ex_mem_o,
    output ex_pkg::branch_t        branch_o,
    output logic                   stall_req_o
);

    ex_stage i_ex_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dispatch_i  (dispatch_i),
        .mem_fwd_i   (mem_fwd_i),
        .timer_64_i  (timer_64_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .ex_mem_o    (ex_mem_o),
        .branch_o    (branch_o),
        .stall_req_o (stall_req_o)
    );

endmodule

`default_nettype wire

// ==== dv/exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    localparam int EXP_CYCLES = 20 + 200 * 2 + 40 * 2 + 100 * 2 + 40 * 40 + 60 * 2 + 60;
    localparam int CYCLE_LIMIT = EXP_CYCLES * 3 / 2;

    logic                   clk;
    logic                   rst_n_i;
    ex_pkg::dispatch_t      disp;
    ex_pkg::mem_fwd_t [1:0] fwd;
    logic [63:0]            timer;
    logic                   stall;
    logic                   flush;
    ex_pkg::ex_mem_t        ex_mem;
    ex_pkg::branch_t        branch;
    logic                   stall_req;

    logic [31:0] lfsr;
    int          cycles;
    int          n_checks;
    int          n_fail;

    ex_pkg::ex_op_e single_ops[19];
    ex_pkg::ex_op_e branch_ops[9];
    ex_pkg::ex_op_e md_ops[7];
    ex_pkg::ex_op_e mem_ops[6];

    exec_top i_exec_top (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dispatch_i  (disp),
        .mem_fwd_i   (fwd),
        .timer_64_i  (timer),
        .stall_i     (stall),
        .flush_i     (flush),
        .ex_mem_o    (ex_mem),
        .branch_o    (branch),
        .stall_req_o (stall_req)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run aborted: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        logic        b;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic ex_pkg::res_sel_e sel_of(input ex_pkg::ex_op_e op);
        case (op)
            ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_SLT, ex_pkg::OP_SLTU,
            ex_pkg::OP_MUL, ex_pkg::OP_MULH, ex_pkg::OP_MULHU, ex_pkg::OP_DIV,
            ex_pkg::OP_DIVU, ex_pkg::OP_MOD, ex_pkg::OP_MODU: return ex_pkg::SEL_ARITH;
            ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_NOR,
            ex_pkg::OP_ORN, ex_pkg::OP_ANDN: return ex_pkg::SEL_LOGIC;
            ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA: return ex_pkg::SEL_SHIFT;
            ex_pkg::OP_LUI, ex_pkg::OP_PCADDU: return ex_pkg::SEL_MOVE;
            ex_pkg::OP_BL, ex_pkg::OP_JIRL: return ex_pkg::SEL_JUMP;
            ex_pkg::OP_RDCNTVL, ex_pkg::OP_RDCNTVH: return ex_pkg::SEL_CNT;
            default: return ex_pkg::SEL_NONE;
        endcase
    endfunction

    function automatic ex_pkg::dispatch_t make_instr(input ex_pkg::ex_op_e op);
        ex_pkg::dispatch_t d;
        d = '0;
        d.valid      = 1'b1;
        d.pc         = rnd(32) & ~32'h3;
        d.op         = op;
        d.sel        = sel_of(op);
        d.rs_addr[0] = 5'(rnd(5));
        d.rs_addr[1] = 5'(rnd(5));
        d.rs_data[0] = rnd(32);
        d.rs_data[1] = rnd(32);
        d.imm        = rnd(32);
        d.use_imm    = 1'(rnd(1));
        d.wen        = 1'b1;
        d.waddr      = 5'(rnd(5));
        d.excp_code  = ex_pkg::EXCP_NONE;
        return d;
    endfunction

    // Newer slot first, register 0 never forwarded
    function automatic logic [31:0] fwd_val(input ex_pkg::dispatch_t d,
                                            input ex_pkg::mem_fwd_t [1:0] f, input int i);
        logic [31:0] v;
        v = d.rs_data[i];
        if (d.rs_addr[i] != 5'd0) begin
            if (f[1].wen && f[1].is_load && f[1].waddr == d.rs_addr[i]) begin
                v = f[1].wdata;
            end else if (f[0].wen && f[0].is_load && f[0].waddr == d.rs_addr[i]) begin
                v = f[0].wdata;
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] muldiv_ref(input ex_pkg::ex_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      p;
        logic [63:0] pu;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        p  = sa * sb;
        pu = {32'd0, a} * {32'd0, b};
        case (op)
            ex_pkg::OP_MUL:   return p[31:0];
            ex_pkg::OP_MULH:  return p[63:32];
            ex_pkg::OP_MULHU: return pu[63:32];
            ex_pkg::OP_DIV:   return (b == 32'd0) ? 32'hffff_ffff : 32'(sa / sb);
            ex_pkg::OP_MOD:   return (b == 32'd0) ? a : 32'(sa % sb);
            ex_pkg::OP_DIVU:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
            default:          return (b == 32'd0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] wdata_ref(input ex_pkg::dispatch_t d, input logic [31:0] a,
                                              input logic [31:0] b, input logic [63:0] t);
        case (d.op)
            ex_pkg::OP_ADD:     return a + b;
            ex_pkg::OP_SUB:     return a - b;
            ex_pkg::OP_SLT:     return {31'd0, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU:    return {31'd0, a < b};
            ex_pkg::OP_AND:     return a & b;
            ex_pkg::OP_OR:      return a | b;
            ex_pkg::OP_XOR:     return a ^ b;
            ex_pkg::OP_NOR:     return ~(a | b);
            ex_pkg::OP_ORN:     return a | ~b;
            ex_pkg::OP_ANDN:    return a & ~b;
            ex_pkg::OP_SLL:     return a << b[4:0];
            ex_pkg::OP_SRL:     return a >> b[4:0];
            ex_pkg::OP_SRA:     return $signed(a) >>> b[4:0];
            ex_pkg::OP_LUI:     return b;
            ex_pkg::OP_PCADDU:  return d.pc + b;
            ex_pkg::OP_BL, ex_pkg::OP_JIRL: return d.pc + 32'd4;
            ex_pkg::OP_RDCNTVL: return t[31:0];
            ex_pkg::OP_RDCNTVH: return t[63:32];
            default: begin
                if (sel_of(d.op) == ex_pkg::SEL_ARITH) begin
                    return muldiv_ref(d.op, a, b);
                end
                return 32'd0;
            end
        endcase
    endfunction

    function automatic ex_pkg::branch_t branch_ref(input ex_pkg::dispatch_t d,
                                                   input logic [31:0] a, input logic [31:0] b);
        ex_pkg::branch_t r;
        logic            c;
        case (d.op)
            ex_pkg::OP_B, ex_pkg::OP_BL, ex_pkg::OP_JIRL: c = 1'b1;
            ex_pkg::OP_BEQ:  c = (a == b);
            ex_pkg::OP_BNE:  c = (a != b);
            ex_pkg::OP_BLT:  c = ($signed(a) < $signed(b));
            ex_pkg::OP_BGE:  c = ($signed(a) >= $signed(b));
            ex_pkg::OP_BLTU: c = (a < b);
            ex_pkg::OP_BGEU: c = (a >= b);
            default:         c = 1'b0;
        endcase
        r.taken  = d.valid & c;
        r.target = (d.op == ex_pkg::OP_JIRL) ? a + d.imm : d.pc + d.imm;
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("ERROR %s got %08h expected %08h", name, got, exp);
            n_fail++;
        end
    endtask

    task automatic check_branch(input ex_pkg::dispatch_t d, input ex_pkg::mem_fwd_t [1:0] f);
        ex_pkg::branch_t e;
        logic [31:0]     b;
        b = d.use_imm ? d.imm : fwd_val(d, f, 1);
        e = branch_ref(d, fwd_val(d, f, 0), b);
        check("branch_o.taken", {31'd0, branch.taken}, {31'd0, e.taken});
        if (e.taken) begin
            check("branch_o.target", branch.target, e.target);
        end
    endtask

    task automatic check_result(input ex_pkg::dispatch_t d, input ex_pkg::mem_fwd_t [1:0] f,
                                input logic [63:0] t);
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     addr;
        logic            ale;
        ex_pkg::branch_t br;
        a    = fwd_val(d, f, 0);
        b    = d.use_imm ? d.imm : fwd_val(d, f, 1);
        addr = a + d.imm;
        ale  = ((d.op == ex_pkg::OP_LD_H || d.op == ex_pkg::OP_ST_H) && addr[0]) ||
               ((d.op == ex_pkg::OP_LD_W || d.op == ex_pkg::OP_ST_W) && addr[1:0] != 2'b00);
        br   = branch_ref(d, a, b);
        check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd1);
        check("ex_mem_o.pc", ex_mem.pc, d.pc);
        check("ex_mem_o.op", {26'd0, ex_mem.op}, {26'd0, d.op});
        check("ex_mem_o.wen", {31'd0, ex_mem.wen}, {31'd0, d.wen & ~ale});
        check("ex_mem_o.waddr", {27'd0, ex_mem.waddr}, {27'd0, d.waddr});
        check("ex_mem_o.wdata", ex_mem.wdata, wdata_ref(d, a, b, t));
        check("ex_mem_o.mem_addr", ex_mem.mem_addr, addr);
        check("ex_mem_o.store_data", ex_mem.store_data, fwd_val(d, f, 1));
        check("ex_mem_o.excp", {31'd0, ex_mem.excp}, {31'd0, ale});
        check("ex_mem_o.excp_code", {28'd0, ex_mem.excp_code},
              ale ? {28'd0, ex_pkg::EXCP_ALE} : {28'd0, ex_pkg::EXCP_NONE});
        check("ex_mem_o.last_in_block", {31'd0, ex_mem.last_in_block}, {31'd0, br.taken});
    endtask

    task automatic run_single(input ex_pkg::dispatch_t d, input ex_pkg::mem_fwd_t [1:0] f,
                              input logic [63:0] t);
        @(posedge clk);
        disp  <= d;
        fwd   <= f;
        timer <= t;
        @(negedge clk);
        check_branch(d, f);
        @(posedge clk);
        disp <= '0;
        @(negedge clk);
        check_result(d, f, t);
    endtask

    task automatic run_muldiv(input ex_pkg::dispatch_t d);
        int high;
        high = 0;
        @(posedge clk);
        disp <= d;
        fwd  <= '0;
        @(negedge clk);
        while (stall_req && high < 60) begin
            check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd0);
            high++;
            @(negedge clk);
        end
        if (stall_req) begin
            $display("Multiply/divide result did not arrive within 60 cycles");
            n_fail++;
        end else if (high < 30) begin
            $display("Stall request dropped after only %0d cycles", high);
            n_fail++;
        end
        @(posedge clk);
        disp <= '0;
        @(negedge clk);
        check_result(d, '0, timer);
    endtask

    task automatic report(input string name, input int fails_before);
        $display("%s: done, %0d errors", name, n_fail - fails_before);
    endtask

    initial begin
        ex_pkg::dispatch_t      d;
        ex_pkg::mem_fwd_t [1:0] f;
        int                     f0;

        clk = 1'b0;
        rst_n_i = 1'b0;
        disp = '0;
        // Unconditional branch with valid low must not be taken
        disp.op = ex_pkg::OP_B;
        fwd = '0;
        timer = 64'd0;
        stall = 1'b0;
        flush = 1'b0;
        lfsr = 32'h90dd8ddd;
        cycles = 0;
        n_checks = 0;
        n_fail = 0;
        single_ops = '{ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_SLT, ex_pkg::OP_SLTU,
                       ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_NOR,
                       ex_pkg::OP_ORN, ex_pkg::OP_ANDN, ex_pkg::OP_SLL, ex_pkg::OP_SRL,
                       ex_pkg::OP_SRA, ex_pkg::OP_LUI, ex_pkg::OP_PCADDU, ex_pkg::OP_BL,
                       ex_pkg::OP_JIRL, ex_pkg::OP_RDCNTVL, ex_pkg::OP_RDCNTVH};
        branch_ops = '{ex_pkg::OP_B, ex_pkg::OP_BL, ex_pkg::OP_JIRL, ex_pkg::OP_BEQ,
                       ex_pkg::OP_BNE, ex_pkg::OP_BLT, ex_pkg::OP_BGE, ex_pkg::OP_BLTU,
                       ex_pkg::OP_BGEU};
        md_ops = '{ex_pkg::OP_MUL, ex_pkg::OP_MULH, ex_pkg::OP_MULHU, ex_pkg::OP_DIV,
                   ex_pkg::OP_DIVU, ex_pkg::OP_MOD, ex_pkg::OP_MODU};
        mem_ops = '{ex_pkg::OP_LD_B, ex_pkg::OP_LD_H, ex_pkg::OP_LD_W, ex_pkg::OP_ST_B,
                    ex_pkg::OP_ST_H, ex_pkg::OP_ST_W};

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        f0 = n_fail;
        check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd0);
        check("ex_mem_o.wen", {31'd0, ex_mem.wen}, 32'd0);
        check("stall_req_o", {31'd0, stall_req}, 32'd0);
        check("branch_o.taken", {31'd0, branch.taken}, 32'd0);
        report("reset", f0);

        f0 = n_fail;
        for (int i = 0; i < 200; i++) begin
            d = make_instr(single_ops[int'(rnd(8)) % 19]);
            run_single(d, '0, {rnd(32), rnd(32)});
        end
        report("single-cycle ops", f0);

        // Slots aimed at the source registers, mixing loads and non-loads
        f0 = n_fail;
        for (int i = 0; i < 40; i++) begin
            d = make_instr(i[0] ? ex_pkg::OP_ST_W : ex_pkg::OP_ADD);
            d.use_imm = 1'b0;
            if (rnd(2) == 32'd0) begin
                d.rs_addr[i % 2] = 5'd0;
            end
            for (int s = 0; s < 2; s++) begin
                f[s].wen     = rnd(3) != 32'd0;
                f[s].is_load = rnd(3) != 32'd0;
                f[s].waddr   = (rnd(1) != 32'd0) ? d.rs_addr[1] : d.rs_addr[0];
                f[s].wdata   = rnd(32);
            end
            run_single(d, f, timer);
        end
        report("forwarding", f0);

        f0 = n_fail;
        for (int i = 0; i < 100; i++) begin
            d = make_instr(branch_ops[int'(rnd(8)) % 9]);
            d.use_imm = 1'b0;
            d.wen     = (d.op == ex_pkg::OP_BL || d.op == ex_pkg::OP_JIRL);
            if (rnd(2) == 32'd0) begin
                d.rs_data[1] = d.rs_data[0];
            end
            run_single(d, '0, timer);
        end
        report("branches", f0);

        f0 = n_fail;
        for (int i = 0; i < 40; i++) begin
            d = make_instr(md_ops[int'(rnd(8)) % 7]);
            d.use_imm = 1'b0;
            if (i < 2) begin
                d.op = i == 0 ? ex_pkg::OP_DIV : ex_pkg::OP_MOD;
                d.rs_data = {32'hffff_ffff, 32'h8000_0000};
            end else if (i < 4) begin
                // Divide by zero, unsigned quotient and signed remainder
                d.op = i == 2 ? ex_pkg::OP_DIVU : ex_pkg::OP_MOD;
                d.rs_data[1] = 32'd0;
            end else if (rnd(3) == 32'd0) begin
                d.rs_data[1] = 32'd0;
            end
            d.sel = sel_of(d.op);
            run_muldiv(d);
        end
        report("multiply/divide", f0);

        f0 = n_fail;
        for (int i = 0; i < 60; i++) begin
            d = make_instr(mem_ops[int'(rnd(8)) % 6]);
            run_single(d, '0, timer);
        end
        d = make_instr(ex_pkg::OP_LD_B);
        @(posedge clk);
        disp <= d;
        @(posedge clk);
        disp  <= make_instr(ex_pkg::OP_ADD);
        stall <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_result(d, '0, timer);
        end
        @(posedge clk);
        flush <= 1'b1;
        disp  <= '0;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        @(negedge clk);
        check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd0);
        check("ex_mem_o.pc", ex_mem.pc, 32'd0);
        check("ex_mem_o.mem_addr", ex_mem.mem_addr, 32'd0);
        // Abort a divide midway while the ADD ahead of it is held
        d = make_instr(ex_pkg::OP_ADD);
        @(posedge clk);
        disp <= d;
        d = make_instr(ex_pkg::OP_DIVU);
        d.use_imm = 1'b0;
        @(posedge clk);
        disp  <= d;
        stall <= 1'b1;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd1);
        check("stall_req_o", {31'd0, stall_req}, 32'd1);
        @(posedge clk);
        flush <= 1'b1;
        disp  <= '0;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        @(negedge clk);
        check("ex_mem_o.valid", {31'd0, ex_mem.valid}, 32'd0);
        // The unit must be idle again and run a new op at full length
        d = make_instr(ex_pkg::OP_MUL);
        d.use_imm = 1'b0;
        run_muldiv(d);
        report("memory, stall and flush", f0);

        $display("checks: %0d, passed: %0d, failed: %0d", n_checks, n_checks - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/ex_pkg.sv
ex/ex_alu.sv
ex/ex_branch.sv
muldiv/muldiv_unit.sv
ex/ex_stage.sv
logic/exec_top.sv
dv/exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module exec_tb -f filelist.f
out="$(./obj_dir/Vexec_tb)"
echo "$out"

if grep -q "Test completed successfully" <<< "$out"; then
    exit 0
fi
exit 1
